/* tb.f */
motion_pkg.sv
dda_axis.sv
dda_executor.sv
move_fifo.sv
cmd_decoder.sv
motion_ctrl_top.sv
motion_ctrl_sva.sv
tb_motion_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the motion controller testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_ctrl \
  -f tb.f -o sim_motion \
  && ./obj_dir/sim_motion \
  || { echo "simulation failed"; exit 1; }

/* tb_motion_ctrl.sv */
// Testbench for the motion controller; sends host words, counts step pulses and checks replies
`timescale 1ns/100ps

module tb_motion_ctrl;

  logic        CLK;
  logic        resetn;
  logic [63:0] word_in;
  logic        word_received;
  logic [63:0] word_reply;
  logic [1:0]  enable;
  logic [1:0]  step;
  logic [1:0]  dir;
  logic        buffer_dtr;
  logic        move_done;

  integer      seed = 32'h8c57_81b1;
  int          steps0;
  int          steps1;
  int          done_count;
  logic [1:0]  exp_dir;
  logic [63:0] last_reply;  // Reply expected before the next counted word
  logic [63:0] exp0;
  logic [63:0] exp1;
  logic [63:0] inc0;
  logic [63:0] inc1;
  logic [1:0]  en_val;

  motion_ctrl_top #(.num_motors(2), .buffer_size(2), .default_clock_divisor(4)) dut0 (
    .CLK (CLK), .resetn (resetn), .word_in (word_in), .word_received (word_received),
    .word_reply (word_reply), .enable (enable), .step (step), .dir (dir),
    .buffer_dtr (buffer_dtr), .move_done (move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
      else stop_with_failure($sformatf("ERROR %s is %h, expected %h", name, got, exp));
  endtask

  // Steps from a constant increment over dur ticks
  function automatic logic [63:0] expected_steps(input logic [31:0] dur, input logic [63:0] inc);
    logic [127:0] product;
    product = {96'd0, dur} * {64'd0, inc};
    return product[127:64];
  endfunction

  // Strobe high for 2 cycles and low for 2
  task automatic send_word(input logic [63:0] w);
    word_in       <= w;
    word_received <= 1'b1;
    repeat (2) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2) @(posedge CLK);
    last_reply = '0;
  endtask

  task automatic send_and_check_reply(input logic [63:0] w, input logic [63:0] new_val);
    word_in       <= w;
    word_received <= 1'b1;
    @(posedge CLK);  // Counted edge
    @(negedge CLK);
    check_value("word_reply", word_reply, last_reply);
    @(posedge CLK);
    word_received <= 1'b0;
    @(negedge CLK);
    check_value("word_reply", word_reply, new_val);
    repeat (2) @(posedge CLK);
    last_reply = new_val;
  endtask

  task automatic send_move(input logic [1:0] d, input logic [31:0] dur,
                           input logic [63:0] i0, input logic [63:0] i1);
    send_word({8'h01, 54'd0, d});
    send_word({32'd0, dur});
    send_word(i0);
    send_word(64'd0);  // Ramp
    send_word(i1);
    send_word(64'd0);
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    @(negedge CLK);
    while (!move_done) begin
      if (n == limit) stop_with_failure("timed out waiting for move_done");
      n++;
      @(negedge CLK);
    end
    @(posedge CLK);
  endtask

  task automatic wait_dtr(input logic level, input int limit);
    int n;
    n = 0;
    @(negedge CLK);
    while (buffer_dtr !== level) begin
      if (n == limit) stop_with_failure("timed out waiting for buffer_dtr to change");
      n++;
      @(negedge CLK);
    end
    @(posedge CLK);
  endtask

  // Counts steps and move_done pulses and checks dir while stepping
  always @(negedge CLK) begin
    if (!resetn) begin
      if (step[0]) steps0++;
      if (step[1]) steps1++;
      if (move_done) done_count++;
      if (step != 2'b00) check_value("dir", {62'd0, dir}, {62'd0, exp_dir});
    end
  end

  initial begin
    resetn        = 1'b1;
    word_in       = '0;
    word_received = 1'b0;
    exp_dir       = '0;
    last_reply    = '0;
    steps0        = 0;
    steps1        = 0;
    done_count    = 0;
    repeat (8) @(posedge CLK);
    resetn <= 1'b0;
    repeat (2) @(posedge CLK);

    // Version reply and then zero for an unknown opcode
    send_and_check_reply(64'hFE00_0000_0000_0000, 64'h0000_0000_0001_0203);
    send_and_check_reply({8'h33, 24'd0, 32'($random(seed))}, 64'd0);

    repeat (2) begin
      en_val = 2'($random(seed));
      send_and_check_reply({8'h0A, 54'd0, en_val}, 64'd0);
      check_value("enable", {62'd0, enable}, {62'd0, en_val});
      send_and_check_reply(64'hFE00_0000_0000_0000, 64'h0000_0000_0001_0203);
      check_value("enable", {62'd0, enable}, {62'd0, en_val});  // Holds across commands
    end

    // Fixed move giving 20 and 10 steps
    exp_dir = 2'b10;
    steps0  = 0;
    steps1  = 0;
    send_move(2'b10, 32'd40, 64'h8000_0000_0000_0000, 64'h4000_0000_0000_0000);
    wait_done(1000);
    check_value("steps0", 64'(steps0), expected_steps(32'd40, 64'h8000_0000_0000_0000));
    check_value("steps1", 64'(steps1), expected_steps(32'd40, 64'h4000_0000_0000_0000));

    // Three long random moves fill the FIFO
    exp_dir    = 2'b01;
    steps0     = 0;
    steps1     = 0;
    done_count = 0;
    exp0       = '0;
    exp1       = '0;
    repeat (3) begin
      inc0 = {$random(seed), $random(seed)};
      inc1 = {$random(seed), $random(seed)};
      exp0 = exp0 + expected_steps(32'd100, inc0);
      exp1 = exp1 + expected_steps(32'd100, inc1);
      send_move(2'b01, 32'd100, inc0, inc1);
    end
    wait_dtr(1'b0, 100);
    wait_done(2000);
    wait_dtr(1'b1, 10);
    wait_done(2000);
    wait_done(2000);
    check_value("steps0", 64'(steps0), exp0);
    check_value("steps1", 64'(steps1), exp1);

    // Slower ticks at divisor 6 with spacing checked by the bound assertions
    send_and_check_reply({8'h20, 48'd0, 8'd6}, 64'd0);
    exp_dir = 2'b11;
    steps0  = 0;
    steps1  = 0;
    inc1    = {$random(seed), $random(seed)};
    send_move(2'b11, 32'd10, 64'h8000_0000_0000_0000, inc1);
    wait_done(2000);
    check_value("steps0", 64'(steps0), expected_steps(32'd10, 64'h8000_0000_0000_0000));
    check_value("steps1", 64'(steps1), expected_steps(32'd10, inc1));
    check_value("move_done count", 64'(done_count), 64'd4);

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* motion_ctrl_sva.sv */
// Concurrent checks on the motion controller outputs; bound into the top level for simulation
`timescale 1ns/100ps

module motion_ctrl_sva #(
  parameter int num_motors = 2
) (
  input logic                                CLK,
  input logic                                resetn,
  input logic [motion_pkg::word_bits-1:0]    word_reply,
  input logic [num_motors-1:0]               enable,
  input logic [num_motors-1:0]               step,
  input logic                                buffer_dtr,
  input logic                                move_done,
  input logic [motion_pkg::divisor_bits-1:0] clock_divisor
);

  logic [3:0] since_step;  // Saturating count of cycles since the last axis 0 step

  always_ff @(posedge CLK) begin
    if (resetn) begin
      since_step <= '0;
    end else if (step[0]) begin
      since_step <= 4'd1;
    end else if (since_step != 4'hF) begin
      since_step <= since_step + 1'b1;
    end
  end

  // Quiet outputs and an empty FIFO out of reset
  a_reset_values: assert property (@(posedge CLK)
    resetn |=> (step == '0 && !move_done && enable == '0 && buffer_dtr && word_reply == '0))
    else $error("outputs not at their reset values");

  // A slot frees only when the executor takes the next move after a move_done
  a_dtr_after_done: assert property (@(posedge CLK) disable iff (resetn)
    $rose(buffer_dtr) |-> $past(move_done))
    else $error("buffer_dtr rose without a move_done in the cycle before");

  // Half-scale increment carries on every second tick of 6 cycles
  a_step_spacing: assert property (@(posedge CLK) disable iff (resetn)
    (clock_divisor == 8'd6 && step[0]) ##1 !move_done
      |-> ##11 (step[0] && since_step == 4'd12))
    else $error("axis 0 steps not 12 cycles apart at divisor 6");

endmodule

bind motion_ctrl_top motion_ctrl_sva #(.num_motors(num_motors)) sva0 (
  .CLK (CLK), .resetn (resetn), .word_reply (word_reply), .enable (enable), .step (step),
  .buffer_dtr (buffer_dtr), .move_done (move_done), .clock_divisor (clock_divisor)
);

/* motion_ctrl_top.sv */
// Top level of the stepper motion controller; connects decoder, move FIFO and DDA executor
`timescale 1ns/100ps

module motion_ctrl_top #(
  parameter int num_motors            = 2,
  parameter int buffer_size           = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                             CLK,
  input  logic                             resetn,
  input  logic [motion_pkg::word_bits-1:0] word_in,
  input  logic                             word_received,
  output logic [motion_pkg::word_bits-1:0] word_reply,
  output logic [num_motors-1:0]            enable,
  output logic [num_motors-1:0]            step,
  output logic [num_motors-1:0]            dir,
  output logic                             buffer_dtr,
  output logic                             move_done
);

  logic [motion_pkg::divisor_bits-1:0]     clock_divisor;
  logic                                    push_move;
  motion_pkg::axis_move_t [num_motors-1:0] push_axes;
  logic [num_motors-1:0]                   push_dir;
  logic [motion_pkg::duration_bits-1:0]    push_duration;
  logic                                    pop_move;
  logic                                    move_avail;
  motion_pkg::axis_move_t [num_motors-1:0] head_axes;
  logic [num_motors-1:0]                   head_dir;
  logic [motion_pkg::duration_bits-1:0]    head_duration;

  cmd_decoder #(
    .num_motors            (num_motors),
    .default_clock_divisor (default_clock_divisor)
  ) dec0 (
    .CLK (CLK), .resetn (resetn), .word_in (word_in), .word_received (word_received),
    .word_reply (word_reply), .enable (enable), .clock_divisor (clock_divisor),
    .push_move (push_move), .push_axes (push_axes), .push_dir (push_dir),
    .push_duration (push_duration)
  );

  move_fifo #(.num_motors(num_motors), .buffer_size(buffer_size)) fifo0 (
    .CLK (CLK), .resetn (resetn), .push_move (push_move), .push_axes (push_axes),
    .push_dir (push_dir), .push_duration (push_duration), .pop_move (pop_move),
    .head_axes (head_axes), .head_dir (head_dir), .head_duration (head_duration),
    .move_avail (move_avail), .buffer_dtr (buffer_dtr)
  );

  dda_executor #(.num_motors(num_motors)) exec0 (
    .CLK (CLK), .resetn (resetn), .clock_divisor (clock_divisor),
    .move_avail (move_avail), .head_axes (head_axes), .head_dir (head_dir),
    .head_duration (head_duration), .pop_move (pop_move), .step (step), .dir (dir),
    .move_done (move_done)
  );

endmodule

/* cmd_decoder.sv */
// Host word parser; answers on the reply word, holds enable and divisor, and pushes moves to the FIFO
`timescale 1ns/100ps

module cmd_decoder #(
  parameter int num_motors            = 2,
  parameter int default_clock_divisor = 32
) (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic [motion_pkg::word_bits-1:0]       word_in,
  input  logic                                   word_received,
  output logic [motion_pkg::word_bits-1:0]       word_reply,
  output logic [num_motors-1:0]                  enable,
  output logic [motion_pkg::divisor_bits-1:0]    clock_divisor,
  output logic                                   push_move,
  output motion_pkg::axis_move_t [num_motors-1:0] push_axes,
  output logic [num_motors-1:0]                  push_dir,
  output logic [motion_pkg::duration_bits-1:0]   push_duration
);

  localparam int cnt_bits = $clog2(2 * num_motors + 1);
  localparam logic [cnt_bits-1:0] last_word = cnt_bits'(2 * num_motors);

  logic                              strobe_q;
  logic                              word_valid;  // One cycle per counted word
  logic [motion_pkg::word_bits-1:0]  word_q;
  motion_pkg::dec_state_e            state;
  logic [cnt_bits-1:0]               word_cnt;    // Words after the header
  motion_pkg::cmd_e                  opcode;

  assign opcode = motion_pkg::cmd_e'(word_q[motion_pkg::word_bits-1 -: 8]);

  // Rising edge of the level strobe
  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_q   <= 1'b0;
      word_valid <= 1'b0;
    end else begin
      strobe_q   <= word_received;
      word_valid <= word_received & ~strobe_q;
    end
  end

  always_ff @(posedge CLK) begin
    word_q <= word_in;
  end

  // Header handling and message sequencing
  always_ff @(posedge CLK) begin
    if (resetn) begin
      state         <= motion_pkg::dec_header;
      word_cnt      <= '0;
      word_reply    <= '0;
      enable        <= '0;
      clock_divisor <= motion_pkg::divisor_bits'(default_clock_divisor);
      push_move     <= 1'b0;
    end else begin
      push_move <= 1'b0;
      if (word_valid) begin
        word_reply <= '0;  // Only a version header answers
        case (state)
          motion_pkg::dec_header: begin
            case (opcode)
              motion_pkg::cmd_step: begin
                word_cnt <= '0;
                state    <= motion_pkg::dec_move_words;
              end
              motion_pkg::cmd_enable: enable <= word_q[num_motors-1:0];
              motion_pkg::cmd_divisor: begin
                clock_divisor <= word_q[motion_pkg::divisor_bits-1:0];
              end
              motion_pkg::cmd_version: begin
                word_reply <= motion_pkg::word_bits'({motion_pkg::version_devel,
                                                      motion_pkg::version_major,
                                                      motion_pkg::version_minor,
                                                      motion_pkg::version_patch});
              end
              default: ;  // Unknown opcode is ignored
            endcase
          end
          motion_pkg::dec_move_words: begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == last_word) begin  // Final ramp word
              push_move <= 1'b1;
              state     <= motion_pkg::dec_header;
            end
          end
          default: state <= motion_pkg::dec_header;
        endcase
      end
    end
  end

  // Move fields, filled word by word
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      if (state == motion_pkg::dec_header && opcode == motion_pkg::cmd_step) begin
        push_dir <= word_q[num_motors-1:0];
      end else if (state == motion_pkg::dec_move_words) begin
        if (word_cnt == '0) begin
          push_duration <= word_q[motion_pkg::duration_bits-1:0];
        end
        for (int i = 0; i < num_motors; i++) begin
          if (word_cnt == cnt_bits'(2 * i + 1))
            push_axes[i].increment <= word_q;
          if (word_cnt == cnt_bits'(2 * i + 2))
            push_axes[i].ramp <= word_q;
        end
      end
    end
  end

endmodule

/* move_fifo.sv */
// Circular buffer of complete moves between the command decoder and the DDA executor
`timescale 1ns/100ps

module move_fifo #(
  parameter int num_motors  = 2,
  parameter int buffer_size = 2
) (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic                                   push_move,
  input  motion_pkg::axis_move_t [num_motors-1:0] push_axes,
  input  logic [num_motors-1:0]                  push_dir,
  input  logic [motion_pkg::duration_bits-1:0]   push_duration,
  input  logic                                   pop_move,
  output motion_pkg::axis_move_t [num_motors-1:0] head_axes,
  output logic [num_motors-1:0]                  head_dir,
  output logic [motion_pkg::duration_bits-1:0]   head_duration,
  output logic                                   move_avail,
  output logic                                   buffer_dtr
);

  localparam int ptr_bits = (buffer_size > 1) ? $clog2(buffer_size) : 1;
  localparam int cnt_bits = $clog2(buffer_size + 1);
  localparam logic [ptr_bits-1:0] last_slot = ptr_bits'(buffer_size - 1);
  localparam logic [cnt_bits-1:0] full_count = cnt_bits'(buffer_size);

  motion_pkg::axis_move_t [num_motors-1:0] axes_mem [buffer_size];
  logic [num_motors-1:0]                   dir_mem [buffer_size];
  logic [motion_pkg::duration_bits-1:0]    duration_mem [buffer_size];

  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                do_push;
  logic                do_pop;

  assign buffer_dtr = (count != full_count);
  assign move_avail = (count != '0);
  assign do_push    = push_move & buffer_dtr;  // Full FIFO drops the move
  assign do_pop     = pop_move & move_avail;

  assign head_axes     = axes_mem[rd_ptr];
  assign head_dir      = dir_mem[rd_ptr];
  assign head_duration = duration_mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_push) begin
      axes_mem[wr_ptr]     <= push_axes;
      dir_mem[wr_ptr]      <= push_dir;
      duration_mem[wr_ptr] <= push_duration;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop) count <= count + 1'b1;
      else if (do_pop && !do_push) count <= count - 1'b1;
    end
  end

endmodule

/* dda_executor.sv */
// Move consumer; divides CLK into DDA ticks, runs one move at a time and drives the axis DDAs
`timescale 1ns/100ps

module dda_executor #(
  parameter int num_motors = 2
) (
  input  logic                                   CLK,
  input  logic                                   resetn,
  input  logic [motion_pkg::divisor_bits-1:0]    clock_divisor,
  input  logic                                   move_avail,
  input  motion_pkg::axis_move_t [num_motors-1:0] head_axes,
  input  logic [num_motors-1:0]                  head_dir,
  input  logic [motion_pkg::duration_bits-1:0]   head_duration,
  output logic                                   pop_move,
  output logic [num_motors-1:0]                  step,
  output logic [num_motors-1:0]                  dir,
  output logic                                   move_done
);

  logic [motion_pkg::divisor_bits-1:0]  div_cnt;
  logic [motion_pkg::divisor_bits-1:0]  cur_div;  // Divisor of the current tick period
  logic                                 tick;
  logic                                 axis_tick;
  motion_pkg::exec_state_e              state;
  logic [motion_pkg::duration_bits-1:0] remaining;

  // Free running tick divider
  assign tick = (div_cnt == cur_div - 1'b1);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= '0;
      cur_div <= motion_pkg::divisor_bits'(1);
    end else if (tick) begin
      div_cnt <= '0;
      cur_div <= (clock_divisor == '0) ? motion_pkg::divisor_bits'(1) : clock_divisor;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Take the FIFO head whenever idle
  assign pop_move  = (state == motion_pkg::exec_idle) & move_avail;
  assign axis_tick = (state == motion_pkg::exec_run) & tick & (remaining != '0);

  always_ff @(posedge CLK) begin
    if (resetn) begin
      state     <= motion_pkg::exec_idle;
      remaining <= '0;
      dir       <= '0;
      move_done <= 1'b0;
    end else begin
      move_done <= 1'b0;
      case (state)
        motion_pkg::exec_idle: begin
          if (pop_move) begin
            remaining <= head_duration;
            dir       <= head_dir;
            state     <= motion_pkg::exec_run;
          end
        end
        motion_pkg::exec_run: begin
          if (remaining == '0) begin
            move_done <= 1'b1;
            state     <= motion_pkg::exec_idle;
          end else if (tick) begin
            remaining <= remaining - 1'b1;
          end
        end
        default: state <= motion_pkg::exec_idle;
      endcase
    end
  end

  for (genvar i = 0; i < num_motors; i++) begin : g_axis
    dda_axis axis0 (
      .CLK    (CLK),
      .resetn (resetn),
      .tick   (axis_tick),
      .load   (pop_move),
      .axis   (head_axes[i]),
      .step   (step[i])
    );
  end

endmodule

/* dda_axis.sv */
// Single axis DDA accumulator with ramped increment; emits a step on each accumulator carry
`timescale 1ns/100ps

module dda_axis (
  input  logic                   CLK,
  input  logic                   resetn,
  input  logic                   tick,
  input  logic                   load,
  input  motion_pkg::axis_move_t axis,
  output logic                   step
);

  logic [motion_pkg::dda_bits-1:0] accum;
  logic [motion_pkg::dda_bits-1:0] increment;  // Working increment, ramps each tick
  logic [motion_pkg::dda_bits-1:0] ramp;
  logic [motion_pkg::dda_bits:0]   sum;        // Carry in the top bit

  assign sum = {1'b0, accum} + {1'b0, increment};

  always_ff @(posedge CLK) begin
    if (load) begin
      accum     <= '0;
      increment <= axis.increment;
      ramp      <= axis.ramp;
    end else if (tick) begin
      accum     <= sum[motion_pkg::dda_bits-1:0];
      increment <= increment + ramp;  // Wraps
    end
  end

  // Step pulse follows a carrying tick
  always_ff @(posedge CLK) begin
    if (resetn) begin
      step <= 1'b0;
    end else begin
      step <= tick & sum[motion_pkg::dda_bits];
    end
  end

endmodule

/* motion_pkg.sv */
// Shared widths, opcodes, FSM states, version constants and the move struct for the motion controller
package motion_pkg;

  // Host bus and datapath widths
  localparam int word_bits     = 64;
  localparam int dda_bits      = 64;  // Increment, ramp and accumulator
  localparam int duration_bits = 32;  // Move length in DDA ticks
  localparam int divisor_bits  = 8;

  // Host command opcodes, carried in the top byte of a header word
  typedef enum logic [7:0] {
    cmd_step    = 8'h01,
    cmd_enable  = 8'h0A,
    cmd_divisor = 8'h20,
    cmd_version = 8'hFE
  } cmd_e;

  // Decoder waits for a header or collects the words of a step message
  typedef enum logic {
    dec_header,
    dec_move_words
  } dec_state_e;

  // Executor is idle or running a move
  typedef enum logic {
    exec_idle,
    exec_run
  } exec_state_e;

  // API version reply fields
  localparam logic [7:0] version_major = 8'd1;
  localparam logic [7:0] version_minor = 8'd2;
  localparam logic [7:0] version_patch = 8'd3;
  localparam logic [7:0] version_devel = 8'd0;

  // One axis of a move
  typedef struct packed {
    logic [dda_bits-1:0] increment;  // Added to the accumulator each tick
    logic [dda_bits-1:0] ramp;       // Added to increment each tick
  } axis_move_t;

endpackage
